/* Bender.yml */
package:
  name: decode_stage

sources:
  - design/cpu_pkg.sv
  - design/decode_ctrl.sv
  - design/reg_file.sv
  - design/reg_pending.sv
  - design/hazard_unit.sv
  - design/forward_sel.sv
  - design/decode.sv
  - target: simulation
    files:
      - sim/decode_tb.sv

/* design/cpu_pkg.sv */
package cpu_pkg;

   // ----------------------------------------------------------------------
   // Machine sizes
   // ----------------------------------------------------------------------
   localparam int XLEN     = 16;
   localparam int NUM_REGS = 8;
   localparam int REG_W    = 3;

   // Instruction classes in bits 15:14
   localparam logic [1:0] CLS_LOAD  = 2'b00;
   localparam logic [1:0] CLS_STORE = 2'b01;
   localparam logic [1:0] CLS_LDI   = 2'b10;
   localparam logic [1:0] CLS_ALU   = 2'b11;

   // ALU operations carried in func
   localparam logic [3:0] ALU_ADD   = 4'd0;
   localparam logic [3:0] ALU_SUB   = 4'd1;
   localparam logic [3:0] ALU_AND   = 4'd2;
   localparam logic [3:0] ALU_OR    = 4'd3;
   localparam logic [3:0] ALU_XOR   = 4'd4;
   localparam logic [3:0] ALU_SLL   = 4'd5;
   localparam logic [3:0] ALU_SRL   = 4'd6;
   localparam logic [3:0] FUNC_HALT = 4'b1111;  // Halt in ALU class

   // Operand forwarding selects
   localparam logic [1:0] FWD_REG = 2'b00;
   localparam logic [1:0] FWD_EX  = 2'b01;
   localparam logic [1:0] FWD_MEM = 2'b10;

   // ALU B source
   localparam logic SRC_REG = 1'b0;
   localparam logic SRC_IMM = 1'b1;

   // ----------------------------------------------------------------------
   // Instruction word in register and immediate views
   // ----------------------------------------------------------------------
   typedef union packed {
      struct packed {
         logic [1:0]       cls;
         logic [REG_W-1:0] ra;
         logic [REG_W-1:0] rb;
         logic [3:0]       func;
         logic [3:0]       d;     // Load/store offset
      } r;
      struct packed {
         logic [1:0]       cls;
         logic [REG_W-1:0] ra;
         logic [REG_W-1:0] rb;
         logic [7:0]       imm;   // LDI constant
      } i;
   } instr_u;

endpackage

/* design/decode.sv */
`timescale 1ns/1ps

module decode import cpu_pkg::*; (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             flushed,
   input  logic [XLEN-1:0]  inst_id,
   input  logic             regwrite,
   input  logic [REG_W-1:0] regwrite_adr,
   input  logic [XLEN-1:0]  regwrite_dat,
   output logic [XLEN-1:0]  rd1_id,
   output logic [XLEN-1:0]  rd2_id,
   output logic [XLEN-1:0]  extended_d_id,
   output logic [REG_W-1:0] regwrite_adr_id,
   output logic [3:0]       alu_op_id,
   output logic             alu_src_b_id,
   output logic [1:0]       forward_a_sel_id,
   output logic [1:0]       forward_b_sel_id,
   output logic             mem_read_id,
   output logic             mem_write_id,
   output logic             regwrite_id,
   output logic             is_halt_id,
   output logic             en_pc,
   output logic             en_ifid,
   output logic             flush_ifid,
   output logic             en_idex,
   output logic             flush_idex
);

   instr_u              inst;
   logic                use_ra, use_rb;
   logic                is_load;
   logic                stall;
   logic [NUM_REGS-1:0] pend_ex, pend_mem;

   assign inst = inst_id;

   // ----------------------------------------------------------------------
   // Immediate from imm for LDI and from d otherwise
   // ----------------------------------------------------------------------
   assign extended_d_id = (inst.i.cls == CLS_LDI) ?
                          {{(XLEN-8){inst.i.imm[7]}}, inst.i.imm} :
                          {{(XLEN-4){inst.r.d[3]}}, inst.r.d};

   decode_ctrl ctrl0 (
      .inst_id         (inst_id),
      .alu_op_id       (alu_op_id),
      .alu_src_b_id    (alu_src_b_id),
      .mem_read_id     (mem_read_id),
      .mem_write_id    (mem_write_id),
      .regwrite_id     (regwrite_id),
      .regwrite_adr_id (regwrite_adr_id),
      .is_halt_id      (is_halt_id),
      .use_ra          (use_ra),
      .use_rb          (use_rb),
      .is_load         (is_load)
   );

   reg_file rf0 (
      .clk          (clk),
      .rst_n        (rst_n),
      .regwrite     (regwrite),
      .regwrite_adr (regwrite_adr),
      .regwrite_dat (regwrite_dat),
      .ra           (inst.r.ra),
      .rb           (inst.r.rb),
      .rd1          (rd1_id),
      .rd2          (rd2_id)
   );

   reg_pending pend0 (
      .clk             (clk),
      .rst_n           (rst_n),
      .flushed         (flushed),
      .stall           (stall),
      .regwrite_id     (regwrite_id),
      .regwrite_adr_id (regwrite_adr_id),
      .pend_ex         (pend_ex),
      .pend_mem        (pend_mem),
      .pend_wb         ()             // WB covered by write-through
   );

   hazard_unit haz0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .flushed    (flushed),
      .is_load    (is_load),
      .use_ra     (use_ra),
      .use_rb     (use_rb),
      .ra         (inst.r.ra),
      .rb         (inst.r.rb),
      .pend_ex    (pend_ex),
      .stall      (stall),
      .en_pc      (en_pc),
      .en_ifid    (en_ifid),
      .flush_ifid (flush_ifid),
      .en_idex    (en_idex),
      .flush_idex (flush_idex)
   );

   forward_sel fwd0 (
      .use_ra           (use_ra),
      .use_rb           (use_rb),
      .ra               (inst.r.ra),
      .rb               (inst.r.rb),
      .pend_ex          (pend_ex),
      .pend_mem         (pend_mem),
      .forward_a_sel_id (forward_a_sel_id),
      .forward_b_sel_id (forward_b_sel_id)
   );

endmodule

/* design/decode_ctrl.sv */
`timescale 1ns/1ps

module decode_ctrl import cpu_pkg::*; (
   input  logic [XLEN-1:0]  inst_id,
   output logic [3:0]       alu_op_id,
   output logic             alu_src_b_id,
   output logic             mem_read_id,
   output logic             mem_write_id,
   output logic             regwrite_id,
   output logic [REG_W-1:0] regwrite_adr_id,
   output logic             is_halt_id,
   output logic             use_ra,
   output logic             use_rb,
   output logic             is_load
);

   instr_u inst;
   logic   func_ok;

   assign inst = inst_id;

   // Known ALU functions
   always_comb begin
      case (inst.r.func)
         ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
         ALU_XOR, ALU_SLL, ALU_SRL: func_ok = 1'b1;
         default:                   func_ok = 1'b0;
      endcase
   end

   // ----------------------------------------------------------------------
   // Control fields per class
   // ----------------------------------------------------------------------
   always_comb begin
      alu_op_id       = ALU_ADD;
      alu_src_b_id    = SRC_IMM;
      mem_read_id     = 1'b0;
      mem_write_id    = 1'b0;
      regwrite_id     = 1'b0;
      regwrite_adr_id = inst.r.ra;
      is_halt_id      = 1'b0;
      use_ra          = 1'b0;
      use_rb          = 1'b0;

      case (inst.r.cls)
         CLS_LOAD: begin
            mem_read_id = 1'b1;        // ra <= mem[rb + d]
            regwrite_id = 1'b1;
            use_rb      = 1'b1;
         end
         CLS_STORE: begin
            mem_write_id = 1'b1;       // mem[rb + d] <= ra
            use_ra       = 1'b1;
            use_rb       = 1'b1;
         end
         CLS_LDI: begin
            regwrite_id     = 1'b1;
            regwrite_adr_id = inst.i.rb;  // Immediate passes through B
         end
         CLS_ALU: begin
            alu_src_b_id = SRC_REG;
            if (inst.r.func == FUNC_HALT) begin
               is_halt_id = 1'b1;
            end else if (func_ok) begin
               alu_op_id   = inst.r.func;
               regwrite_id = 1'b1;
               use_ra      = 1'b1;
               use_rb      = 1'b1;
            end
            // Unknown func falls through as a no-op
         end
      endcase
   end

   assign is_load = (inst.r.cls == CLS_LOAD);

endmodule

/* design/forward_sel.sv */
`timescale 1ns/1ps

module forward_sel import cpu_pkg::*; (
   input  logic                use_ra,
   input  logic                use_rb,
   input  logic [REG_W-1:0]    ra,
   input  logic [REG_W-1:0]    rb,
   input  logic [NUM_REGS-1:0] pend_ex,
   input  logic [NUM_REGS-1:0] pend_mem,
   output logic [1:0]          forward_a_sel_id,
   output logic [1:0]          forward_b_sel_id
);

   // Youngest producer wins and WB comes from the register file bypass
   function automatic logic [1:0] pick_src(
      input logic                used,
      input logic [REG_W-1:0]    adr,
      input logic [NUM_REGS-1:0] ex,
      input logic [NUM_REGS-1:0] mem
   );
      if (!used) begin
         return FWD_REG;
      end
      if (ex[adr]) begin
         return FWD_EX;
      end
      if (mem[adr]) begin
         return FWD_MEM;
      end
      return FWD_REG;
   endfunction

   assign forward_a_sel_id = pick_src(use_ra, ra, pend_ex, pend_mem);
   assign forward_b_sel_id = pick_src(use_rb, rb, pend_ex, pend_mem);

endmodule

/* design/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit import cpu_pkg::*; (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                flushed,
   input  logic                is_load,
   input  logic                use_ra,
   input  logic                use_rb,
   input  logic [REG_W-1:0]    ra,
   input  logic [REG_W-1:0]    rb,
   input  logic [NUM_REGS-1:0] pend_ex,
   output logic                stall,
   output logic                en_pc,
   output logic                en_ifid,
   output logic                flush_ifid,
   output logic                en_idex,
   output logic                flush_idex
);

   logic load_ex;
   logic ex_hit;

   // Load now entering EX
   always_ff @(posedge clk) begin
      if (!rst_n || flushed) begin
         load_ex <= 1'b0;
      end else begin
         load_ex <= is_load & ~stall;
      end
   end

   // Source produced by the load still in EX
   assign ex_hit = (use_ra & pend_ex[ra]) | (use_rb & pend_ex[rb]);

   // Redirect takes precedence so the PC can load its target
   assign stall = load_ex & ex_hit & ~flushed;

   // ----------------------------------------------------------------------
   // Pipeline register control
   // ----------------------------------------------------------------------
   assign en_pc      = ~stall;
   assign en_ifid    = ~stall;
   assign flush_ifid = flushed;
   assign en_idex    = 1'b1;              // Bubble is clocked in
   assign flush_idex = stall | flushed;

endmodule

/* design/reg_file.sv */
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             regwrite,
   input  logic [REG_W-1:0] regwrite_adr,
   input  logic [XLEN-1:0]  regwrite_dat,
   input  logic [REG_W-1:0] ra,
   input  logic [REG_W-1:0] rb,
   output logic [XLEN-1:0]  rd1,
   output logic [XLEN-1:0]  rd2
);

   logic [XLEN-1:0] regs [NUM_REGS];

   // ----------------------------------------------------------------------
   // Write port
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         regs <= '{default: '0};
      end else if (regwrite) begin
         regs[regwrite_adr] <= regwrite_dat;
      end
   end

   // Read ports with write-through from WB
   always_comb begin
      if (regwrite && (regwrite_adr == ra)) begin
         rd1 = regwrite_dat;
      end else begin
         rd1 = regs[ra];
      end

      if (regwrite && (regwrite_adr == rb)) begin
         rd2 = regwrite_dat;
      end else begin
         rd2 = regs[rb];
      end
   end

endmodule

/* design/reg_pending.sv */
`timescale 1ns/1ps

module reg_pending import cpu_pkg::*; (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                flushed,
   input  logic                stall,
   input  logic                regwrite_id,
   input  logic [REG_W-1:0]    regwrite_adr_id,
   output logic [NUM_REGS-1:0] pend_ex,
   output logic [NUM_REGS-1:0] pend_mem,
   output logic [NUM_REGS-1:0] pend_wb
);

   logic [NUM_REGS-1:0] dest_mask;

   // One-hot destination of the instruction leaving decode
   always_comb begin
      dest_mask                  = '0;
      dest_mask[regwrite_adr_id] = regwrite_id & ~stall;  // Bubble marks nothing
   end

   // ----------------------------------------------------------------------
   // Scoreboard shift EX -> MEM -> WB
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n || flushed) begin
         pend_ex  <= '0;
         pend_mem <= '0;
         pend_wb  <= '0;
      end else begin
         pend_ex  <= dest_mask;
         pend_mem <= pend_ex;
         pend_wb  <= pend_mem;   // Dropped at the following edge
      end
   end

endmodule

/* sim/decode_tb.sv */
`timescale 1ns/1ps

module decode_tb import cpu_pkg::*; ();

   localparam int PERIOD    = 100;
   localparam int N_ROWS    = 17;
   localparam int N_RAND    = 200;
   localparam int WD_CYCLES = N_ROWS + N_RAND + 20;  // Reset and slack

   // mem_read, mem_write, regwrite, halt, alu_src_b
   localparam logic [4:0] CTL_NONE  = 5'b00000;
   localparam logic [4:0] CTL_LOAD  = 5'b10101;
   localparam logic [4:0] CTL_STORE = 5'b01001;
   localparam logic [4:0] CTL_LDI   = 5'b00101;
   localparam logic [4:0] CTL_ALU   = 5'b00100;
   localparam logic [4:0] CTL_HALT  = 5'b00010;

   typedef struct packed {
      logic [15:0] inst;
      logic        wb_en;
      logic [2:0]  wb_adr;
      logic [15:0] wb_dat;
      logic        flush;
      logic [1:0]  fa;
      logic [1:0]  fb;
      logic        stall;
      logic [2:0]  dest;
      logic [3:0]  op;
      logic [4:0]  ctl;
      logic [15:0] ext;
   } row_t;

   logic        clk, rst_n, flushed, regwrite;
   logic [2:0]  regwrite_adr, regwrite_adr_id;
   logic [15:0] inst_id, regwrite_dat, rd1_id, rd2_id, extended_d_id;
   logic [3:0]  alu_op_id;
   logic [1:0]  forward_a_sel_id, forward_b_sel_id;
   logic        alu_src_b_id, mem_read_id, mem_write_id, regwrite_id, is_halt_id;
   logic        en_pc, en_ifid, flush_ifid, en_idex, flush_idex;

   row_t        rows [N_ROWS];
   int          n_rows;
   logic [15:0] ref_regs [NUM_REGS];  // Reference register model
   logic [31:0] seed;

   decode dut0 (
      .clk (clk), .rst_n (rst_n), .flushed (flushed), .inst_id (inst_id),
      .regwrite (regwrite), .regwrite_adr (regwrite_adr), .regwrite_dat (regwrite_dat),
      .rd1_id (rd1_id), .rd2_id (rd2_id), .extended_d_id (extended_d_id),
      .regwrite_adr_id (regwrite_adr_id), .alu_op_id (alu_op_id),
      .alu_src_b_id (alu_src_b_id), .forward_a_sel_id (forward_a_sel_id),
      .forward_b_sel_id (forward_b_sel_id), .mem_read_id (mem_read_id),
      .mem_write_id (mem_write_id), .regwrite_id (regwrite_id), .is_halt_id (is_halt_id),
      .en_pc (en_pc), .en_ifid (en_ifid), .flush_ifid (flush_ifid),
      .en_idex (en_idex), .flush_idex (flush_idex)
   );

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(WD_CYCLES * PERIOD);
      $display("Timeout: the run did not finish within %0d clock cycles", WD_CYCLES);
      $display("Testbench failed");
      $fatal(1, "Watchdog expired");
   end

   // ---------------------------------------------------------------------
   // Instruction encoders
   // ---------------------------------------------------------------------
   function automatic logic [15:0] enc_alu(input logic [3:0] func, input logic [2:0] ra,
                                           input logic [2:0] rb);
      return {CLS_ALU, ra, rb, func, 4'h0};
   endfunction

   function automatic logic [15:0] enc_ld(input logic [2:0] ra, input logic [2:0] rb,
                                          input logic [3:0] d);
      return {CLS_LOAD, ra, rb, 4'h0, d};
   endfunction

   function automatic logic [15:0] enc_st(input logic [2:0] ra, input logic [2:0] rb,
                                          input logic [3:0] d);
      return {CLS_STORE, ra, rb, 4'h0, d};
   endfunction

   function automatic logic [15:0] enc_ldi(input logic [2:0] rb, input logic [7:0] imm);
      return {CLS_LDI, 3'd0, rb, imm};
   endfunction

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
         $display("Testbench failed");
         $fatal(1, "Stopping at first mismatch");
      end
   endtask

   task automatic add_row(input logic [15:0] inst, input logic wb_en, input logic [2:0] wb_adr,
                          input logic [15:0] wb_dat, input logic flush, input logic [1:0] fa,
                          input logic [1:0] fb, input logic stall, input logic [2:0] dest,
                          input logic [3:0] op, input logic [4:0] ctl, input logic [15:0] ext);
      rows[n_rows] = {inst, wb_en, wb_adr, wb_dat, flush, fa, fb, stall, dest, op, ctl, ext};
      n_rows++;
   endtask

   // Drive on the rising edge and settle by the falling edge
   task automatic apply_inputs(input logic [15:0] inst, input logic wb_en,
                               input logic [2:0] wb_adr, input logic [15:0] wb_dat,
                               input logic flush);
      @(posedge clk);
      inst_id      <= inst;
      regwrite     <= wb_en;
      regwrite_adr <= wb_adr;
      regwrite_dat <= wb_dat;
      flushed      <= flush;
      @(negedge clk);
   endtask

   // Read ports against the model and then commit the write
   task automatic check_reads(input logic [15:0] inst, input logic wb_en,
                              input logic [2:0] wb_adr, input logic [15:0] wb_dat,
                              input string tag);
      logic [15:0] exp1;
      logic [15:0] exp2;
      exp1 = (wb_en && wb_adr == inst[13:11]) ? wb_dat : ref_regs[inst[13:11]];
      exp2 = (wb_en && wb_adr == inst[10:8]) ? wb_dat : ref_regs[inst[10:8]];
      check_value(rd1_id, exp1, {tag, " rd1"});
      check_value(rd2_id, exp2, {tag, " rd2"});
      if (wb_en) ref_regs[wb_adr] = wb_dat;
   endtask

   task automatic build_table();
      n_rows = 0;
      add_row(enc_alu(4'd7, 3'd0, 3'd0), 1'b0, 3'd0, 16'h0, 1'b0, FWD_REG, FWD_REG, 1'b0,
              3'd0, ALU_ADD, CTL_NONE, 16'h0000);    // Nop right after reset
      add_row(enc_ldi(3'd1, 8'h85), 1'b0, 3'd0, 16'h0, 1'b0, FWD_REG, FWD_REG, 1'b0,
              3'd1, ALU_ADD, CTL_LDI, 16'hFF85);
      add_row(enc_alu(ALU_ADD, 3'd2, 3'd1), 1'b0, 3'd0, 16'h0, 1'b0, FWD_REG, FWD_EX, 1'b0,
              3'd2, ALU_ADD, CTL_ALU, 16'h0000);
      add_row(enc_alu(ALU_OR, 3'd3, 3'd1), 1'b0, 3'd0, 16'h0, 1'b0, FWD_REG, FWD_MEM, 1'b0,
              3'd3, ALU_OR, CTL_ALU, 16'h0000);     // One in between
      add_row(enc_alu(ALU_XOR, 3'd4, 3'd1), 1'b1, 3'd1, 16'h1234, 1'b0, FWD_REG, FWD_REG,
              1'b0, 3'd4, ALU_XOR, CTL_ALU, 16'h0000);
      add_row(enc_ld(3'd5, 3'd6, 4'hE), 1'b1, 3'd2, 16'hBEEF, 1'b0, FWD_REG, FWD_REG, 1'b0,
              3'd5, ALU_ADD, CTL_LOAD, 16'hFFFE);
      add_row(enc_alu(ALU_ADD, 3'd5, 3'd3), 1'b0, 3'd0, 16'h0, 1'b0, FWD_EX, FWD_REG, 1'b1,
              3'd5, ALU_ADD, CTL_ALU, 16'h0000);    // Load-use bubble
      add_row(enc_alu(ALU_ADD, 3'd5, 3'd3), 1'b0, 3'd0, 16'h0, 1'b0, FWD_MEM, FWD_REG, 1'b0,
              3'd5, ALU_ADD, CTL_ALU, 16'h0000);
      add_row(enc_st(3'd5, 3'd7, 4'h3), 1'b0, 3'd0, 16'h0, 1'b0, FWD_EX, FWD_REG, 1'b0,
              3'd5, ALU_ADD, CTL_STORE, 16'h0003);
      add_row(enc_alu(ALU_ADD, 3'd6, 3'd6), 1'b0, 3'd0, 16'h0, 1'b0, FWD_REG, FWD_REG, 1'b0,
              3'd6, ALU_ADD, CTL_ALU, 16'h0000);
      add_row(enc_alu(ALU_AND, 3'd7, 3'd6), 1'b0, 3'd0, 16'h0, 1'b1, FWD_REG, FWD_EX, 1'b0,
              3'd7, ALU_AND, CTL_ALU, 16'h0000);    // Redirect
      add_row(enc_alu(ALU_ADD, 3'd6, 3'd6), 1'b0, 3'd0, 16'h0, 1'b0, FWD_REG, FWD_REG, 1'b0,
              3'd6, ALU_ADD, CTL_ALU, 16'h0000);
      add_row(enc_alu(FUNC_HALT, 3'd0, 3'd0), 1'b0, 3'd0, 16'h0, 1'b0, FWD_REG, FWD_REG,
              1'b0, 3'd0, ALU_ADD, CTL_HALT, 16'h0000);
      add_row(enc_ldi(3'd2, 8'h7F), 1'b0, 3'd0, 16'h0, 1'b0, FWD_REG, FWD_REG, 1'b0,
              3'd2, ALU_ADD, CTL_LDI, 16'h007F);
      add_row(enc_alu(ALU_SLL, 3'd3, 3'd2), 1'b0, 3'd0, 16'h0, 1'b0, FWD_REG, FWD_EX, 1'b0,
              3'd3, ALU_SLL, CTL_ALU, 16'h0000);
      add_row(enc_alu(ALU_SRL, 3'd2, 3'd3), 1'b0, 3'd0, 16'h0, 1'b0, FWD_MEM, FWD_EX, 1'b0,
              3'd2, ALU_SRL, CTL_ALU, 16'h0000);
      add_row(enc_alu(4'd7, 3'd0, 3'd0), 1'b0, 3'd0, 16'h0, 1'b0, FWD_REG, FWD_REG, 1'b0,
              3'd0, ALU_ADD, CTL_NONE, 16'h0000);
   endtask

   // ---------------------------------------------------------------------
   // Main sequence
   // ---------------------------------------------------------------------
   initial begin
      row_t        r;
      string       tag;
      logic [15:0] inst_r;
      logic [15:0] dat_r;
      logic [2:0]  adr_r;
      logic        wen_r;
      rst_n        = 1'b0;
      flushed      = 1'b0;
      inst_id      = enc_alu(4'd7, 3'd0, 3'd0);
      regwrite     = 1'b0;
      regwrite_adr = 3'd0;
      regwrite_dat = 16'h0;
      seed         = 32'd75574;
      for (int k = 0; k < NUM_REGS; k++) ref_regs[k] = 16'h0;
      build_table();
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;

      for (int i = 0; i < n_rows; i++) begin
         r   = rows[i];
         tag = $sformatf("row %0d", i);
         apply_inputs(r.inst, r.wb_en, r.wb_adr, r.wb_dat, r.flush);
         check_value(forward_a_sel_id, r.fa, {tag, " forward A"});
         check_value(forward_b_sel_id, r.fb, {tag, " forward B"});
         check_value(en_pc, !r.stall, {tag, " en_pc"});
         check_value(en_ifid, !r.stall, {tag, " en_ifid"});
         check_value(en_idex, 1'b1, {tag, " en_idex"});
         check_value(flush_ifid, r.flush, {tag, " flush_ifid"});
         check_value(flush_idex, r.stall | r.flush, {tag, " flush_idex"});
         check_value(regwrite_adr_id, r.dest, {tag, " destination"});
         check_value(alu_op_id, r.op, {tag, " alu_op"});
         check_value({mem_read_id, mem_write_id, regwrite_id, is_halt_id, alu_src_b_id},
                     r.ctl, {tag, " control flags"});
         check_value(extended_d_id, r.ext, {tag, " immediate"});
         check_reads(r.inst, r.wb_en, r.wb_adr, r.wb_dat, tag);
      end

      // Random writes and reads against the model
      for (int i = 0; i < N_RAND; i++) begin
         seed   = lcg_next(seed);
         inst_r = seed[31:16];
         seed   = lcg_next(seed);
         wen_r  = seed[31];
         adr_r  = seed[30:28];
         dat_r  = seed[23:8];
         if (seed[27]) adr_r = inst_r[13:11];   // Hit the write-through path often
         apply_inputs(inst_r, wen_r, adr_r, dat_r, 1'b0);
         check_reads(inst_r, wen_r, adr_r, dat_r, $sformatf("random step %0d", i));
      end

      $display("Testbench passed");
      $finish;
   end

endmodule

/* sources.f */
design/cpu_pkg.sv
design/decode_ctrl.sv
design/reg_file.sv
design/reg_pending.sv
design/hazard_unit.sv
design/forward_sel.sv
design/decode.sv
sim/decode_tb.sv
